// File: hw/mc_link_pkg.sv
// ----------------------------------------
// Manycore link definitions
// Packet widths and payload types of the
// fwd request and rev response links
// ----------------------------------------

package mc_link_pkg;

  // Fwd request packet width in bits
  localparam int mc_fwd_width_c = 80;

  // Rev response packet width in bits
  localparam int mc_rev_width_c = 40;

  // Request payload, carried as one opaque vector
  typedef logic [mc_fwd_width_c-1:0] mc_fwd_packet_t;

  // Response payload, also opaque
  typedef logic [mc_rev_width_c-1:0] mc_rev_packet_t;

  // The adapters never look inside these vectors.
  // Address, data and opcode fields stay packed as the
  // manycore tile hands them over, and the far end of
  // the network unpacks the same bits unchanged.
  //
  // Both widths set the number of body flits that
  // follow each header on the wormhole side:
  //   fwd  80 bits -> 3 flits of 32
  //   rev  40 bits -> 2 flits of 32
  //
  // The rev net must stay free of fwd traffic so a
  // response can always drain, which is why the two
  // links keep separate adapters.

endpackage

// File: hw/wh_pkg.sv
// ----------------------------------------
// Wormhole network definitions
// Flit, coordinate and length types and
// the layout of the header flit
// ----------------------------------------

package wh_pkg;

  // Default flit width
  localparam int wh_flit_width_c = 32;

  // Destination coordinate
  localparam int wh_cord_width_c = 8;
  typedef logic [wh_cord_width_c-1:0] wh_cord_t;

  // Body flits that follow the header
  localparam int wh_len_width_c = 4;
  typedef logic [wh_len_width_c-1:0] wh_len_t;

  // Header flit layout
  //   [7:0]   destination coordinate
  //   [11:8]  body length in flits
  //   above   zero
  localparam int wh_cord_lsb_c = 0;
  localparam int wh_len_lsb_c  = 8;

  // A header needs wh_len_lsb_c + wh_len_width_c bits,
  // so any flit width of 12 or more can carry it.
  // Routers only look at the coordinate and length;
  // body flits pass through them untouched until the
  // length count runs out and the worm releases its path.
  // Up to 15 body flits fit the length field.

endpackage

// File: hw/wh_flit_fifo.sv
// ----------------------------------------
// Flit FIFO
// Small valid/ready buffer ahead of the
// unpacker on the network receive side
// ----------------------------------------

`timescale 1ns/1ps

module wh_flit_fifo
 #(parameter int flit_width_p = 32
  ,parameter int fifo_els_p   = 2
  )
  (input  logic                    clk_i
  ,input  logic                    rst_i

  // Write side
  ,input  logic                    v_i
  ,input  logic [flit_width_p-1:0] data_i
  ,output logic                    ready_o

  // Read side
  ,output logic                    v_o
  ,output logic [flit_width_p-1:0] data_o
  ,input  logic                    ready_i
  );

  localparam int ptr_width_lp = (fifo_els_p > 1) ? $clog2(fifo_els_p) : 1;
  localparam int cnt_width_lp = $clog2(fifo_els_p + 1);

  typedef logic [flit_width_p-1:0] flit_t;
  typedef logic [ptr_width_lp-1:0] ptr_t;
  typedef logic [cnt_width_lp-1:0] cnt_t;

  localparam ptr_t last_ptr_lp = ptr_t'(fifo_els_p - 1);
  localparam cnt_t full_cnt_lp = cnt_t'(fifo_els_p);

  flit_t mem_r [fifo_els_p];
  ptr_t  wr_ptr_r;
  ptr_t  rd_ptr_r;
  cnt_t  count_r;
  logic  enq;
  logic  deq;

  assign ready_o = (count_r != full_cnt_lp);
  assign v_o     = (count_r != '0);
  assign data_o  = mem_r[rd_ptr_r];

  assign enq = v_i & ready_o;
  assign deq = v_o & ready_i;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wr_ptr_r <= '0;
      rd_ptr_r <= '0;
      count_r  <= '0;
    end else begin
      if (enq) begin
        wr_ptr_r <= (wr_ptr_r == last_ptr_lp) ? '0 : ptr_t'(wr_ptr_r + 1'b1);
      end
      if (deq) begin
        rd_ptr_r <= (rd_ptr_r == last_ptr_lp) ? '0 : ptr_t'(rd_ptr_r + 1'b1);
      end
      // Simultaneous push and pop leaves the count alone
      if (enq && !deq) begin
        count_r <= cnt_t'(count_r + 1'b1);
      end else if (deq && !enq) begin
        count_r <= cnt_t'(count_r - 1'b1);
      end
    end
  end

  // Storage
  always_ff @(posedge clk_i) begin
    if (enq) begin
      mem_r[wr_ptr_r] <= data_i;
    end
  end

endmodule

// File: hw/wh_flit_unpacker.sv
// ----------------------------------------
// Flit unpacker
// Collects a header and its body flits
// and presents them as one wide packet
// ----------------------------------------

`timescale 1ns/1ps

module wh_flit_unpacker
 #(parameter int flit_width_p = 32
  ,parameter int wide_width_p = 80
  )
  (input  logic                    clk_i
  ,input  logic                    rst_i

  // Flits from the buffer
  ,input  logic                    flit_v_i
  ,input  logic [flit_width_p-1:0] flit_i
  ,output logic                    flit_ready_o

  // Rebuilt packet
  ,output logic                    wide_v_o
  ,output logic [wide_width_p-1:0] wide_o
  ,input  logic                    wide_ready_i
  );

  localparam int body_flits_lp = (wide_width_p + flit_width_p - 1) / flit_width_p;
  localparam int padded_width_lp = body_flits_lp * flit_width_p;

  typedef logic [padded_width_lp-1:0] padded_t;

  typedef enum logic [1:0] {
    up_header_s,
    up_body_s,
    up_hold_s
  } up_state_e;

  up_state_e       state_r;
  wh_pkg::wh_len_t len_r;
  wh_pkg::wh_len_t cnt_r;
  wh_pkg::wh_len_t hdr_len;
  padded_t         wide_r;
  logic            flit_xfer;
  logic            last_body;

  assign hdr_len   = flit_i[wh_pkg::wh_len_lsb_c +: wh_pkg::wh_len_width_c];
  assign flit_xfer = flit_v_i & flit_ready_o;
  assign last_body = (wh_pkg::wh_len_t'(cnt_r + 1'b1) == len_r);

  // Stall the buffer while a finished packet waits
  assign flit_ready_o = (state_r != up_hold_s);
  assign wide_v_o     = (state_r == up_hold_s);

  // Padding bits of the last flit fall off here
  assign wide_o = wide_r[wide_width_p-1:0];

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_r <= up_header_s;
      len_r   <= '0;
      cnt_r   <= '0;
    end else begin
      case (state_r)
        up_header_s: begin
          if (flit_xfer) begin
            len_r   <= hdr_len;
            cnt_r   <= '0;
            // Empty body means the packet is already complete
            state_r <= (hdr_len == '0) ? up_hold_s : up_body_s;
          end
        end
        up_body_s: begin
          if (flit_xfer) begin
            cnt_r <= wh_pkg::wh_len_t'(cnt_r + 1'b1);
            if (last_body) begin
              state_r <= up_hold_s;
            end
          end
        end
        up_hold_s: begin
          if (wide_ready_i) begin
            state_r <= up_header_s;
          end
        end
        default: state_r <= up_header_s;
      endcase
    end
  end

  // Body flits land lowest slice first
  always_ff @(posedge clk_i) begin
    if (flit_xfer && (state_r == up_header_s)) begin
      wide_r <= '0;
    end else if (flit_xfer && (state_r == up_body_s) && (cnt_r < body_flits_lp)) begin
      wide_r[cnt_r*flit_width_p +: flit_width_p] <= flit_i;
    end
  end

endmodule

// File: hw/wh_link_adapter.sv
// ----------------------------------------
// Wormhole link adapter
// One net: packs wide packets into header
// and body flits, unpacks received flits
// ----------------------------------------

`timescale 1ns/1ps

module wh_link_adapter
 #(parameter int flit_width_p = 32
  ,parameter int wide_width_p = 80
  ,parameter int fifo_els_p   = 2
  )
  (input  logic                    clk_i
  ,input  logic                    rst_i
  ,input  wh_pkg::wh_cord_t        dest_cord_i

  // Wide packets from the tile
  ,input  logic                    wide_v_i
  ,input  logic [wide_width_p-1:0] wide_i
  ,output logic                    wide_ready_o

  // Wide packets to the tile
  ,output logic                    wide_v_o
  ,output logic [wide_width_p-1:0] wide_o
  ,input  logic                    wide_ready_i

  // Flits to the network
  ,output logic                    wh_v_o
  ,output logic [flit_width_p-1:0] wh_data_o
  ,input  logic                    wh_ready_i

  // Flits from the network
  ,input  logic                    wh_v_i
  ,input  logic [flit_width_p-1:0] wh_data_i
  ,output logic                    wh_ready_o
  );

  localparam int body_flits_lp = (wide_width_p + flit_width_p - 1) / flit_width_p;
  localparam int padded_width_lp = body_flits_lp * flit_width_p;

  typedef logic [flit_width_p-1:0]    flit_t;
  typedef logic [padded_width_lp-1:0] padded_t;

  localparam wh_pkg::wh_len_t body_len_lp  = wh_pkg::wh_len_t'(body_flits_lp);
  localparam wh_pkg::wh_len_t last_cnt_lp  = wh_pkg::wh_len_t'(body_flits_lp - 1);

  typedef enum logic [1:0] {
    pk_idle_s,
    pk_header_s,
    pk_body_s
  } pk_state_e;

  pk_state_e        state_r;
  wh_pkg::wh_len_t  cnt_r;
  wh_pkg::wh_cord_t cord_r;
  padded_t          pkt_r;
  flit_t            header_flit;
  logic             wide_xfer;
  logic             flit_xfer;

  // Receive path wiring
  logic  fifo_v;
  flit_t fifo_data;
  logic  fifo_ready;

  assign wide_ready_o = (state_r == pk_idle_s);
  assign wide_xfer    = wide_v_i & wide_ready_o;
  assign flit_xfer    = wh_v_o & wh_ready_i;

  // Header from the captured coordinate, length fixed by the packet width
  always_comb begin
    header_flit = '0;
    header_flit[wh_pkg::wh_cord_lsb_c +: wh_pkg::wh_cord_width_c] = cord_r;
    header_flit[wh_pkg::wh_len_lsb_c +: wh_pkg::wh_len_width_c]   = body_len_lp;
  end

  assign wh_v_o    = (state_r != pk_idle_s);
  assign wh_data_o = (state_r == pk_header_s) ? header_flit
                                               : pkt_r[cnt_r*flit_width_p +: flit_width_p];

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_r <= pk_idle_s;
      cnt_r   <= '0;
    end else begin
      case (state_r)
        pk_idle_s: begin
          if (wide_xfer) begin
            state_r <= pk_header_s;
          end
        end
        pk_header_s: begin
          if (flit_xfer) begin
            cnt_r   <= '0;
            state_r <= pk_body_s;
          end
        end
        pk_body_s: begin
          if (flit_xfer) begin
            if (cnt_r == last_cnt_lp) begin
              state_r <= pk_idle_s;
            end else begin
              cnt_r <= wh_pkg::wh_len_t'(cnt_r + 1'b1);
            end
          end
        end
        default: state_r <= pk_idle_s;
      endcase
    end
  end

  // Packet and coordinate held for the whole worm; zero fill above the packet
  always_ff @(posedge clk_i) begin
    if (wide_xfer) begin
      pkt_r  <= padded_t'(wide_i);
      cord_r <= dest_cord_i;
    end
  end

  wh_flit_fifo
 #(.flit_width_p(flit_width_p)
  ,.fifo_els_p  (fifo_els_p  )
  ) i_wh_flit_fifo
  (.clk_i  (clk_i     )
  ,.rst_i  (rst_i     )
  ,.v_i    (wh_v_i    )
  ,.data_i (wh_data_i )
  ,.ready_o(wh_ready_o)
  ,.v_o    (fifo_v    )
  ,.data_o (fifo_data )
  ,.ready_i(fifo_ready)
  );

  wh_flit_unpacker
 #(.flit_width_p(flit_width_p)
  ,.wide_width_p(wide_width_p)
  ) i_wh_flit_unpacker
  (.clk_i       (clk_i       )
  ,.rst_i       (rst_i       )
  ,.flit_v_i    (fifo_v      )
  ,.flit_i      (fifo_data   )
  ,.flit_ready_o(fifo_ready  )
  ,.wide_v_o    (wide_v_o    )
  ,.wide_o      (wide_o      )
  ,.wide_ready_i(wide_ready_i)
  );

endmodule

// File: hw/mc_link_to_wormhole.sv
// ----------------------------------------
// Manycore link to wormhole bridge
// Separate fwd and rev adapters so that
// requests and responses never block
// ----------------------------------------

`timescale 1ns/1ps

module mc_link_to_wormhole
 #(parameter int flit_width_p = wh_pkg::wh_flit_width_c
  ,parameter int fifo_els_p   = 2
  )
  (input  logic                        clk_i
  ,input  logic                        rst_i
  // Stable while packets are in flight
  ,input  wh_pkg::wh_cord_t            dest_cord_i

  // Manycore fwd requests
  ,input  logic                        mc_fwd_v_i
  ,input  mc_link_pkg::mc_fwd_packet_t mc_fwd_data_i
  ,output logic                        mc_fwd_ready_o
  ,output logic                        mc_fwd_v_o
  ,output mc_link_pkg::mc_fwd_packet_t mc_fwd_data_o
  ,input  logic                        mc_fwd_ready_i

  // Manycore rev responses
  ,input  logic                        mc_rev_v_i
  ,input  mc_link_pkg::mc_rev_packet_t mc_rev_data_i
  ,output logic                        mc_rev_ready_o
  ,output logic                        mc_rev_v_o
  ,output mc_link_pkg::mc_rev_packet_t mc_rev_data_o
  ,input  logic                        mc_rev_ready_i

  // Wormhole fwd net
  ,output logic                        wh_fwd_v_o
  ,output logic [flit_width_p-1:0]     wh_fwd_data_o
  ,input  logic                        wh_fwd_ready_i
  ,input  logic                        wh_fwd_v_i
  ,input  logic [flit_width_p-1:0]     wh_fwd_data_i
  ,output logic                        wh_fwd_ready_o

  // Wormhole rev net
  ,output logic                        wh_rev_v_o
  ,output logic [flit_width_p-1:0]     wh_rev_data_o
  ,input  logic                        wh_rev_ready_i
  ,input  logic                        wh_rev_v_i
  ,input  logic [flit_width_p-1:0]     wh_rev_data_i
  ,output logic                        wh_rev_ready_o
  );

  wh_link_adapter
 #(.flit_width_p(flit_width_p)
  ,.wide_width_p(mc_link_pkg::mc_fwd_width_c)
  ,.fifo_els_p  (fifo_els_p)
  ) i_fwd_adapter
  (.clk_i(clk_i), .rst_i(rst_i), .dest_cord_i(dest_cord_i)
  ,.wide_v_i(mc_fwd_v_i), .wide_i(mc_fwd_data_i), .wide_ready_o(mc_fwd_ready_o)
  ,.wide_v_o(mc_fwd_v_o), .wide_o(mc_fwd_data_o), .wide_ready_i(mc_fwd_ready_i)
  ,.wh_v_o(wh_fwd_v_o), .wh_data_o(wh_fwd_data_o), .wh_ready_i(wh_fwd_ready_i)
  ,.wh_v_i(wh_fwd_v_i), .wh_data_i(wh_fwd_data_i), .wh_ready_o(wh_fwd_ready_o)
  );

  wh_link_adapter
 #(.flit_width_p(flit_width_p)
  ,.wide_width_p(mc_link_pkg::mc_rev_width_c)
  ,.fifo_els_p  (fifo_els_p)
  ) i_rev_adapter
  (.clk_i(clk_i), .rst_i(rst_i), .dest_cord_i(dest_cord_i)
  ,.wide_v_i(mc_rev_v_i), .wide_i(mc_rev_data_i), .wide_ready_o(mc_rev_ready_o)
  ,.wide_v_o(mc_rev_v_o), .wide_o(mc_rev_data_o), .wide_ready_i(mc_rev_ready_i)
  ,.wh_v_o(wh_rev_v_o), .wh_data_o(wh_rev_data_o), .wh_ready_i(wh_rev_ready_i)
  ,.wh_v_i(wh_rev_v_i), .wh_data_i(wh_rev_data_i), .wh_ready_o(wh_rev_ready_o)
  );

endmodule

// File: sim/tb_mc_link_to_wormhole.sv
// ----------------------------------------
// Testbench for the wormhole bridge
// Network model, reference flits, packing,
// unpacking and back-pressure loopback
// ----------------------------------------

`timescale 1ns/1ps

module tb_mc_link_to_wormhole;

  localparam int clk_period_lp = 20;
  localparam int flit_w_lp     = 32;
  localparam int loop_pkts_lp  = 20;
  // Watchdog budget counts every packet of every test
  localparam int total_pkts_lp = 2 + 4 + 2 * loop_pkts_lp;
  localparam int timeout_lp    = (total_pkts_lp * 200 + 100) * clk_period_lp;

  logic                 clk_i;
  logic                 rst_i;
  logic [7:0]           dest_cord_i;
  logic                 mc_fwd_v_i;
  logic [79:0]          mc_fwd_data_i;
  logic                 mc_fwd_ready_o;
  logic                 mc_fwd_v_o;
  logic [79:0]          mc_fwd_data_o;
  logic                 mc_fwd_ready_i = 1'b1;
  logic                 mc_rev_v_i;
  logic [39:0]          mc_rev_data_i;
  logic                 mc_rev_ready_o;
  logic                 mc_rev_v_o;
  logic [39:0]          mc_rev_data_o;
  logic                 mc_rev_ready_i = 1'b1;
  logic                 wh_fwd_v_o;
  logic [flit_w_lp-1:0] wh_fwd_data_o;
  logic                 wh_fwd_ready_i;
  logic                 wh_fwd_v_i;
  logic [flit_w_lp-1:0] wh_fwd_data_i;
  logic                 wh_fwd_ready_o;
  logic                 wh_rev_v_o;
  logic [flit_w_lp-1:0] wh_rev_data_o;
  logic                 wh_rev_ready_i;
  logic                 wh_rev_v_i;
  logic [flit_w_lp-1:0] wh_rev_data_i;
  logic                 wh_rev_ready_o;

  // Network model controls
  logic                 loop_en;
  logic                 bp_en;
  logic                 net_fwd_ok = 1'b1;
  logic                 net_rev_ok = 1'b1;
  logic                 inj_fwd_v;
  logic                 inj_rev_v;
  logic [flit_w_lp-1:0] inj_fwd_data;
  logic [flit_w_lp-1:0] inj_rev_data;

  logic [flit_w_lp-1:0] fwd_flit_q[$];
  logic [flit_w_lp-1:0] rev_flit_q[$];
  logic [flit_w_lp-1:0] inj_fwd_q[$];
  logic [flit_w_lp-1:0] inj_rev_q[$];
  logic [79:0]          fwd_got_q[$];
  logic [39:0]          rev_got_q[$];
  logic [79:0]          exp_fwd_q[$];
  logic [39:0]          exp_rev_q[$];
  int fwd_in_flits = 0;
  int rev_in_flits = 0;
  int fwd_pkts_out = 0;
  int rev_pkts_out = 0;
  int check_errs   = 0;
  int assert_errs  = 0;
  int tests_passed = 0;
  int tests_failed = 0;

  mc_link_to_wormhole
 #(.flit_width_p(flit_w_lp)
  ,.fifo_els_p  (2)
  ) i_mc_link_to_wormhole (.*);

  // Loopback sends each net's out flits straight back to its in port
  assign wh_fwd_v_i     = loop_en ? (wh_fwd_v_o & net_fwd_ok) : inj_fwd_v;
  assign wh_fwd_data_i  = loop_en ? wh_fwd_data_o : inj_fwd_data;
  assign wh_fwd_ready_i = loop_en ? (wh_fwd_ready_o & net_fwd_ok) : net_fwd_ok;
  assign wh_rev_v_i     = loop_en ? (wh_rev_v_o & net_rev_ok) : inj_rev_v;
  assign wh_rev_data_i  = loop_en ? wh_rev_data_o : inj_rev_data;
  assign wh_rev_ready_i = loop_en ? (wh_rev_ready_o & net_rev_ok) : net_rev_ok;

  initial begin
    clk_i = 1'b0;
    forever #(clk_period_lp / 2) clk_i = ~clk_i;
  end

  // Random stalls on both network and tile sides
  always @(posedge clk_i) begin
    #2;
    net_fwd_ok     = !bp_en || (($urandom % 4) != 0);
    net_rev_ok     = !bp_en || (($urandom % 4) != 0);
    mc_fwd_ready_i = !bp_en || (($urandom % 3) != 0);
    mc_rev_ready_i = !bp_en || (($urandom % 3) != 0);
  end

  // Monitors sample at the falling edge where every signal has settled
  always @(negedge clk_i) begin
    if (wh_fwd_v_o && wh_fwd_ready_i) fwd_flit_q.push_back(wh_fwd_data_o);
    if (wh_rev_v_o && wh_rev_ready_i) rev_flit_q.push_back(wh_rev_data_o);
    if (wh_fwd_v_i && wh_fwd_ready_o) fwd_in_flits <= fwd_in_flits + 1;
    if (wh_rev_v_i && wh_rev_ready_o) rev_in_flits <= rev_in_flits + 1;
    if (mc_fwd_v_o && mc_fwd_ready_i) begin
      fwd_got_q.push_back(mc_fwd_data_o);
      fwd_pkts_out <= fwd_pkts_out + 1;
    end
    if (mc_rev_v_o && mc_rev_ready_i) begin
      rev_got_q.push_back(mc_rev_data_o);
      rev_pkts_out <= rev_pkts_out + 1;
    end
  end

  task automatic count_assert_fail(input string what);
    assert_errs++;
    $display("ERROR %0t: %s", $time, what);
  endtask

  a_reset: assert property (@(negedge clk_i)
    rst_i |=> !(mc_fwd_v_o || mc_rev_v_o || wh_fwd_v_o || wh_rev_v_o))
    else count_assert_fail("valid output high after reset");
  a_rev_header: assert property (@(negedge clk_i) disable iff (rst_i)
    (mc_rev_v_i && mc_rev_ready_o) |=> (wh_rev_v_o && wh_rev_data_o[11:8] == 4'd2))
    else count_assert_fail("rev header late or wrong");
  a_wh_fwd_hold: assert property (@(negedge clk_i) disable iff (rst_i)
    (wh_fwd_v_o && !wh_fwd_ready_i) |=> (wh_fwd_v_o && $stable(wh_fwd_data_o)))
    else count_assert_fail("wh fwd flit changed under stall");
  a_wh_rev_hold: assert property (@(negedge clk_i) disable iff (rst_i)
    (wh_rev_v_o && !wh_rev_ready_i) |=> (wh_rev_v_o && $stable(wh_rev_data_o)))
    else count_assert_fail("wh rev flit changed under stall");
  a_mc_fwd_hold: assert property (@(negedge clk_i) disable iff (rst_i)
    (mc_fwd_v_o && !mc_fwd_ready_i) |=> (mc_fwd_v_o && $stable(mc_fwd_data_o)))
    else count_assert_fail("mc fwd packet changed under stall");
  a_mc_rev_hold: assert property (@(negedge clk_i) disable iff (rst_i)
    (mc_rev_v_o && !mc_rev_ready_i) |=> (mc_rev_v_o && $stable(mc_rev_data_o)))
    else count_assert_fail("mc rev packet changed under stall");
  // A wide packet needs all its flits in the FIFO at least a cycle earlier
  a_fwd_after_body: assert property (@(negedge clk_i) disable iff (rst_i)
    mc_fwd_v_o |-> ($past(fwd_in_flits) >= (fwd_pkts_out + 1) * 4))
    else count_assert_fail("fwd packet before last flit");
  a_rev_after_body: assert property (@(negedge clk_i) disable iff (rst_i)
    mc_rev_v_o |-> ($past(rev_in_flits) >= (rev_pkts_out + 1) * 3))
    else count_assert_fail("rev packet before last flit");

  // Expected flit idx of a packet with the header at index 0
  // Body slices follow with zero fill above the packet
  function automatic logic [31:0] expected_flit(input logic [127:0] pkt, input int width,
                                                input logic [7:0] cord, input int idx);
    logic [127:0] masked;
    int           n;
    n      = (width + 31) / 32;
    masked = pkt & ((128'd1 << width) - 128'd1);
    if (idx == 0) return {20'd0, 4'(n), cord};
    return masked[(idx-1)*32 +: 32];
  endfunction

  task automatic check_value(input logic [127:0] got, input logic [127:0] exp,
                             input string what);
    assert (got == exp) else begin
      check_errs++;
      $display("ERROR %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic report_test(input string name, input int errs_before);
    if (check_errs + assert_errs == errs_before) begin
      tests_passed++;
      $display("PASS  %s", name);
    end else begin
      tests_failed++;
      $display("FAIL  %s", name);
    end
  endtask

  // Called 2 ns after a rising edge; returns at the same offset
  task automatic send_fwd(input logic [79:0] pkt);
    logic taken;
    mc_fwd_v_i    = 1'b1;
    mc_fwd_data_i = pkt;
    taken         = 1'b0;
    while (!taken) begin
      @(negedge clk_i);
      taken = mc_fwd_ready_o;
      @(posedge clk_i);
      #2;
    end
    mc_fwd_v_i = 1'b0;
  endtask

  task automatic send_rev(input logic [39:0] pkt);
    logic taken;
    mc_rev_v_i    = 1'b1;
    mc_rev_data_i = pkt;
    taken         = 1'b0;
    while (!taken) begin
      @(negedge clk_i);
      taken = mc_rev_ready_o;
      @(posedge clk_i);
      #2;
    end
    mc_rev_v_i = 1'b0;
  endtask

  // Drives both injection queues onto the nets side by side
  task automatic inject_flits();
    logic f_go;
    logic r_go;
    while (inj_fwd_q.size() > 0 || inj_rev_q.size() > 0) begin
      inj_fwd_v = (inj_fwd_q.size() > 0);
      inj_rev_v = (inj_rev_q.size() > 0);
      if (inj_fwd_v) inj_fwd_data = inj_fwd_q[0];
      if (inj_rev_v) inj_rev_data = inj_rev_q[0];
      @(negedge clk_i);
      f_go = inj_fwd_v && wh_fwd_ready_o;
      r_go = inj_rev_v && wh_rev_ready_o;
      @(posedge clk_i);
      #2;
      if (f_go) void'(inj_fwd_q.pop_front());
      if (r_go) void'(inj_rev_q.pop_front());
    end
    inj_fwd_v = 1'b0;
    inj_rev_v = 1'b0;
  endtask

  task automatic wait_flits(input int nf, input int nr);
    while (fwd_flit_q.size() < nf || rev_flit_q.size() < nr) @(posedge clk_i);
    #2;
  endtask

  task automatic wait_packets(input int nf, input int nr);
    while (fwd_got_q.size() < nf || rev_got_q.size() < nr) @(posedge clk_i);
    #2;
  endtask

  initial begin
    #(timeout_lp);
    $display("Watchdog expired: the DUT stopped moving packets");
    $display("SIMULATION FAILED");
    $finish;
  end

  initial begin
    int           errs;
    int           base_f;
    int           base_r;
    logic [79:0]  fp;
    logic [79:0]  fp_l;
    logic [39:0]  rp;
    logic [39:0]  rp_l;
    logic [127:0] acc;
    logic [31:0]  flit;
    void'($urandom(32'hdf3e_5e65));
    rst_i         = 1'b1;
    dest_cord_i   = 8'h00;
    mc_fwd_v_i    = 1'b0;
    mc_fwd_data_i = '0;
    mc_rev_v_i    = 1'b0;
    mc_rev_data_i = '0;
    loop_en       = 1'b0;
    bp_en         = 1'b0;
    inj_fwd_v     = 1'b0;
    inj_rev_v     = 1'b0;
    inj_fwd_data  = '0;
    inj_rev_data  = '0;
    repeat (5) @(posedge clk_i);
    #2;
    rst_i = 1'b0;

    errs = check_errs + assert_errs;
    check_value(128'({mc_fwd_v_o, mc_rev_v_o, wh_fwd_v_o, wh_rev_v_o}), '0, "valids after reset");
    report_test("reset state", errs);

    errs        = check_errs + assert_errs;
    base_f      = fwd_flit_q.size();
    dest_cord_i = 8'h35;
    fp          = 80'({$urandom, $urandom, $urandom});
    send_fwd(fp);
    wait_flits(base_f + 4, rev_flit_q.size());
    for (int i = 0; i < 4; i++) begin
      check_value(128'(fwd_flit_q[base_f+i]), 128'(expected_flit(128'(fp), 80, 8'h35, i)),
                  "fwd flit");
    end
    report_test("fwd packing", errs);

    errs        = check_errs + assert_errs;
    base_r      = rev_flit_q.size();
    dest_cord_i = 8'h5a;
    rp          = 40'({$urandom, $urandom});
    send_rev(rp);
    wait_flits(fwd_flit_q.size(), base_r + 3);
    for (int i = 0; i < 3; i++) begin
      check_value(128'(rev_flit_q[base_r+i]), 128'(expected_flit(128'(rp), 40, 8'h5a, i)),
                  "rev flit");
    end
    report_test("rev packing", errs);

    // Two worms per net injected in parallel so fwd and rev interleave
    errs   = check_errs + assert_errs;
    base_f = fwd_got_q.size();
    base_r = rev_got_q.size();
    exp_fwd_q.delete();
    exp_rev_q.delete();
    for (int k = 0; k < 2; k++) begin
      acc = '0;
      inj_fwd_q.push_back(expected_flit('0, 80, 8'h21, 0));
      for (int j = 0; j < 3; j++) begin
        flit             = $urandom;
        acc[j*32 +: 32]  = flit;
        inj_fwd_q.push_back(flit);
      end
      exp_fwd_q.push_back(acc[79:0]);
      acc = '0;
      inj_rev_q.push_back(expected_flit('0, 40, 8'h12, 0));
      for (int j = 0; j < 2; j++) begin
        flit             = $urandom;
        acc[j*32 +: 32]  = flit;
        inj_rev_q.push_back(flit);
      end
      exp_rev_q.push_back(acc[39:0]);
    end
    inject_flits();
    wait_packets(base_f + 2, base_r + 2);
    for (int k = 0; k < 2; k++) begin
      check_value(128'(fwd_got_q[base_f+k]), 128'(exp_fwd_q[k]), "unpacked fwd");
      check_value(128'(rev_got_q[base_r+k]), 128'(exp_rev_q[k]), "unpacked rev");
    end
    report_test("unpacking", errs);

    errs   = check_errs + assert_errs;
    base_f = fwd_got_q.size();
    base_r = rev_got_q.size();
    exp_fwd_q.delete();
    exp_rev_q.delete();
    loop_en = 1'b1;
    bp_en   = 1'b1;
    fork
      begin
        for (int k = 0; k < loop_pkts_lp; k++) begin
          fp_l = 80'({$urandom, $urandom, $urandom});
          exp_fwd_q.push_back(fp_l);
          send_fwd(fp_l);
        end
      end
      begin
        for (int k = 0; k < loop_pkts_lp; k++) begin
          rp_l = 40'({$urandom, $urandom});
          exp_rev_q.push_back(rp_l);
          send_rev(rp_l);
        end
      end
    join
    wait_packets(base_f + loop_pkts_lp, base_r + loop_pkts_lp);
    bp_en = 1'b0;
    for (int k = 0; k < loop_pkts_lp; k++) begin
      check_value(128'(fwd_got_q[base_f+k]), 128'(exp_fwd_q[k]), "loopback fwd");
      check_value(128'(rev_got_q[base_r+k]), 128'(exp_rev_q[k]), "loopback rev");
    end
    report_test("back-pressure loopback", errs);

    $display("Tests: %0d passed, %0d failed, %0d errors", tests_passed, tests_failed,
             check_errs + assert_errs);
    if (tests_failed == 0 && check_errs + assert_errs == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

// File: sim.f
hw/mc_link_pkg.sv
hw/wh_pkg.sv
hw/wh_flit_fifo.sv
hw/wh_flit_unpacker.sv
hw/wh_link_adapter.sv
hw/mc_link_to_wormhole.sv
sim/tb_mc_link_to_wormhole.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0
TOP       ?= tb_mc_link_to_wormhole
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := SIMULATION PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# The recipe status comes from grep, so a missing pass line fails the target
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
